// File: ddr_pkg.sv
// Types shared by everything that touches the external DDR Wishbone port.
// The loader, the frame writer and the arbiter import this package.

package ddr_pkg;

    // DDR word address
    typedef logic [28:0] ddr_addr_t;

    // One DDR data word
    typedef logic [63:0] ddr_data_t;

    // Byte-lane select, one bit per byte of ddr_data_t
    typedef logic [7:0] ddr_sel_t;

    // Which master currently holds the DDR port
    typedef enum logic [1:0] {
        arb_idle,
        arb_loader,
        arb_writer
    } arb_owner_e;

endpackage

// File: game_pkg.sv
// Types for the game side of the adapter.
// Covers the ROM byte stream toward the game and the pixel stream from it.

package game_pkg;

    // Byte address of the ROM stream
    typedef logic [22:0] prog_addr_t;

    // One ROM byte
    typedef logic [7:0] prog_byte_t;

    // RGB 5-6-5 pixel
    typedef logic [15:0] pixel_t;

    // ROM length, counted in DDR words
    typedef logic [15:0] load_len_t;

    // Pixels packed into one 64-bit DDR word
    localparam int PIXELS_PER_WORD = 4;

endpackage

// File: rom_loader.sv
// ROM loader. Reads a ROM image from DDR one word at a time and hands it to
// the game as byte writes, least significant byte first.
// A dl_start pulse with a non-zero dl_len starts the transfer.

`timescale 1ns/1ns

module rom_loader import ddr_pkg::*, game_pkg::*; #(
    parameter ddr_addr_t LOAD_BASE = '0
) (
    input  logic       clk_sys,
    input  logic       rst_n,
    // Download request from the game side
    input  logic       dl_start,
    input  load_len_t  dl_len,
    output logic       downloading,
    // Byte stream toward the game
    output logic       prog_we,
    output prog_addr_t prog_addr,
    output prog_byte_t prog_data,
    input  logic       prog_rdy,
    // Wishbone master port
    output logic       ld_cyc,
    output logic       ld_stb,
    output logic       ld_we,
    output ddr_addr_t  ld_adr,
    output ddr_data_t  ld_dat_w,
    output ddr_sel_t   ld_sel,
    input  ddr_data_t  ld_dat_r,
    input  logic       ld_ack
);

    localparam int BYTES_PER_WORD = $bits(ddr_data_t) / $bits(prog_byte_t);
    localparam int BW             = $clog2(BYTES_PER_WORD);

    typedef enum logic [1:0] {
        ld_idle,
        ld_read,
        ld_send
    } ld_state_e;

    ld_state_e     state;
    load_len_t     len_r;
    load_len_t     word_idx;
    logic [BW-1:0] byte_idx;
    ddr_data_t     word_r;
    logic          last_word;
    logic          last_byte;

    assign last_word = (word_idx == len_r - load_len_t'(1));
    assign last_byte = (byte_idx == BW'(BYTES_PER_WORD - 1));

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ld_idle;
            len_r     <= '0;
            word_idx  <= '0;
            byte_idx  <= '0;
            prog_addr <= '0;
        end else begin
            case (state)
                ld_idle: begin
                    // An empty image never starts a transfer
                    if (dl_start && dl_len != '0) begin
                        state     <= ld_read;
                        len_r     <= dl_len;
                        word_idx  <= '0;
                        prog_addr <= '0;
                    end
                end
                ld_read: begin
                    if (ld_ack) begin
                        state    <= ld_send;
                        byte_idx <= '0;
                    end
                end
                ld_send: begin
                    if (prog_rdy) begin
                        prog_addr <= prog_addr + prog_addr_t'(1);
                        byte_idx  <= byte_idx + BW'(1);
                        if (last_byte) begin
                            if (last_word) begin
                                state <= ld_idle;
                            end else begin
                                state    <= ld_read;
                                word_idx <= word_idx + load_len_t'(1);
                            end
                        end
                    end
                end
                default: state <= ld_idle;
            endcase
        end
    end

    // Word buffer, shifted down one byte per completed write
    always_ff @(posedge clk_sys) begin
        if (state == ld_read && ld_ack) begin
            word_r <= ld_dat_r;
        end else if (state == ld_send && prog_rdy) begin
            word_r <= word_r >> $bits(prog_byte_t);
        end
    end

    assign downloading = (state != ld_idle);
    assign prog_we     = (state == ld_send);
    assign prog_data   = word_r[$bits(prog_byte_t)-1:0];

    // Read-only master
    assign ld_cyc   = (state == ld_read);
    assign ld_stb   = ld_cyc;
    assign ld_we    = 1'b0;
    assign ld_adr   = LOAD_BASE + ddr_addr_t'(word_idx);
    assign ld_dat_w = '0;
    assign ld_sel   = '1;

endmodule

// File: frame_writer.sv
// Frame writer. Packs game pixels four to a DDR word and writes the words
// to a linear frame buffer starting at FB_BASE.
// frame_start restarts the buffer; back-pressure shows on pxl_ready.

`timescale 1ns/1ns

module frame_writer import ddr_pkg::*, game_pkg::*; #(
    parameter ddr_addr_t FB_BASE = '0
) (
    input  logic      clk_sys,
    input  logic      rst_n,
    // Pixel stream from the game
    input  logic      frame_start,
    input  logic      pxl_valid,
    input  pixel_t    pxl_data,
    output logic      pxl_ready,
    // Wishbone master port
    output logic      fw_cyc,
    output logic      fw_stb,
    output logic      fw_we,
    output ddr_addr_t fw_adr,
    output ddr_data_t fw_dat_w,
    output ddr_sel_t  fw_sel,
    // Write-only master, read data is never looked at
    input  ddr_data_t fw_dat_r,
    input  logic      fw_ack
);

    localparam int SW = $clog2(PIXELS_PER_WORD);
    localparam int PW = $bits(pixel_t);

    // Collector stage
    ddr_data_t     coll_data;
    logic [SW-1:0] coll_cnt;
    logic          coll_full;
    // Pending stage, the word on the bus
    ddr_data_t     pend_data;
    ddr_addr_t     pend_adr;
    logic          pend_valid;
    ddr_addr_t     word_cnt;

    logic          accept;
    logic          move;
    logic [SW-1:0] slot;

    assign pxl_ready = !(coll_full && pend_valid);
    assign accept    = pxl_valid && pxl_ready;
    // Pending must have been empty a full cycle so that cyc drops after ack
    assign move      = coll_full && !pend_valid;
    // A pixel arriving with frame_start is the first of the new frame
    assign slot      = frame_start ? '0 : coll_cnt;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            coll_cnt   <= '0;
            coll_full  <= 1'b0;
            pend_valid <= 1'b0;
            word_cnt   <= '0;
        end else begin
            if (fw_ack) begin
                pend_valid <= 1'b0;
            end
            if (move) begin
                pend_valid <= 1'b1;
                coll_full  <= 1'b0;
                word_cnt   <= word_cnt + ddr_addr_t'(1);
            end
            // Drop any collected pixels, a pending word still goes out
            if (frame_start) begin
                coll_cnt  <= '0;
                coll_full <= 1'b0;
                word_cnt  <= '0;
            end
            if (accept) begin
                coll_cnt <= slot + SW'(1);
                if (slot == SW'(PIXELS_PER_WORD - 1)) begin
                    coll_full <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (accept) begin
            coll_data[slot*PW +: PW] <= pxl_data;
        end
        if (move) begin
            pend_data <= coll_data;
            pend_adr  <= FB_BASE + word_cnt;
        end
    end

    assign fw_cyc   = pend_valid;
    assign fw_stb   = pend_valid;
    assign fw_we    = 1'b1;
    assign fw_adr   = pend_adr;
    assign fw_dat_w = pend_data;
    assign fw_sel   = '1;

endmodule

// File: ddr_arbiter.sv
// Arbiter for the single DDR Wishbone port. The loader wins when both
// masters ask from idle; a grant stays until its owner drops cyc.
// Grant and bus mux are combinational, so no cycles are added.

`timescale 1ns/1ns

module ddr_arbiter import ddr_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst_n,
    // Loader master
    input  logic      ld_cyc,
    input  logic      ld_stb,
    input  logic      ld_we,
    input  ddr_addr_t ld_adr,
    input  ddr_data_t ld_dat_w,
    input  ddr_sel_t  ld_sel,
    output ddr_data_t ld_dat_r,
    output logic      ld_ack,
    // Frame writer master
    input  logic      fw_cyc,
    input  logic      fw_stb,
    input  logic      fw_we,
    input  ddr_addr_t fw_adr,
    input  ddr_data_t fw_dat_w,
    input  ddr_sel_t  fw_sel,
    output ddr_data_t fw_dat_r,
    output logic      fw_ack,
    // External DDR port
    output logic      ddr_cyc,
    output logic      ddr_stb,
    output logic      ddr_we,
    output ddr_addr_t ddr_adr,
    output ddr_data_t ddr_dat_w,
    output ddr_sel_t  ddr_sel,
    input  ddr_data_t ddr_dat_r,
    input  logic      ddr_ack
);

    arb_owner_e owner;
    arb_owner_e grant;

    // Current owner keeps the port while cyc is up, else fixed priority
    always_comb begin
        if (owner == arb_loader && ld_cyc) begin
            grant = arb_loader;
        end else if (owner == arb_writer && fw_cyc) begin
            grant = arb_writer;
        end else if (ld_cyc) begin
            grant = arb_loader;
        end else if (fw_cyc) begin
            grant = arb_writer;
        end else begin
            grant = arb_idle;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            owner <= arb_idle;
        end else begin
            owner <= grant;
        end
    end

    always_comb begin
        case (grant)
            arb_loader: begin
                {ddr_cyc, ddr_stb, ddr_we} = {ld_cyc, ld_stb, ld_we};
                ddr_adr   = ld_adr;
                ddr_dat_w = ld_dat_w;
                ddr_sel   = ld_sel;
            end
            arb_writer: begin
                {ddr_cyc, ddr_stb, ddr_we} = {fw_cyc, fw_stb, fw_we};
                ddr_adr   = fw_adr;
                ddr_dat_w = fw_dat_w;
                ddr_sel   = fw_sel;
            end
            default: begin
                {ddr_cyc, ddr_stb, ddr_we} = 3'b000;
                ddr_adr   = '0;
                ddr_dat_w = '0;
                ddr_sel   = '0;
            end
        endcase
    end

    // Read data fans out, ack only reaches the owner
    assign ld_dat_r = ddr_dat_r;
    assign fw_dat_r = ddr_dat_r;
    assign ld_ack   = ddr_ack && (grant == arb_loader);
    assign fw_ack   = ddr_ack && (grant == arb_writer);

endmodule

// File: mister_ddr_top.sv
// DDR sharing core of the frame adapter. Connects the ROM loader and the
// frame writer to one external DDR Wishbone port through the arbiter.
// LOAD_BASE and FB_BASE place the ROM image and the frame buffer in DDR.

`timescale 1ns/1ns

module mister_ddr_top import ddr_pkg::*, game_pkg::*; #(
    parameter ddr_addr_t LOAD_BASE = ddr_addr_t'('h100),
    parameter ddr_addr_t FB_BASE   = ddr_addr_t'('h800)
) (
    input  logic       clk_sys,
    input  logic       rst_n,
    // ROM download
    input  logic       dl_start,
    input  load_len_t  dl_len,
    output logic       downloading,
    output logic       prog_we,
    output prog_addr_t prog_addr,
    output prog_byte_t prog_data,
    input  logic       prog_rdy,
    // Pixels
    input  logic       frame_start,
    input  logic       pxl_valid,
    input  pixel_t     pxl_data,
    output logic       pxl_ready,
    // DDR Wishbone port
    output logic       ddr_cyc,
    output logic       ddr_stb,
    output logic       ddr_we,
    output ddr_addr_t  ddr_adr,
    output ddr_data_t  ddr_dat_w,
    output ddr_sel_t   ddr_sel,
    input  ddr_data_t  ddr_dat_r,
    input  logic       ddr_ack
);

    logic      ld_cyc, ld_stb, ld_we, ld_ack;
    ddr_addr_t ld_adr;
    ddr_data_t ld_dat_w, ld_dat_r;
    ddr_sel_t  ld_sel;

    logic      fw_cyc, fw_stb, fw_we, fw_ack;
    ddr_addr_t fw_adr;
    ddr_data_t fw_dat_w, fw_dat_r;
    ddr_sel_t  fw_sel;

    rom_loader #(.LOAD_BASE(LOAD_BASE)) u_loader (
        .clk_sys     (clk_sys),     .rst_n       (rst_n),
        .dl_start    (dl_start),    .dl_len      (dl_len),
        .downloading (downloading), .prog_we     (prog_we),
        .prog_addr   (prog_addr),   .prog_data   (prog_data),
        .prog_rdy    (prog_rdy),
        .ld_cyc      (ld_cyc),      .ld_stb      (ld_stb),
        .ld_we       (ld_we),       .ld_adr      (ld_adr),
        .ld_dat_w    (ld_dat_w),    .ld_sel      (ld_sel),
        .ld_dat_r    (ld_dat_r),    .ld_ack      (ld_ack)
    );

    frame_writer #(.FB_BASE(FB_BASE)) u_writer (
        .clk_sys     (clk_sys),     .rst_n       (rst_n),
        .frame_start (frame_start), .pxl_valid   (pxl_valid),
        .pxl_data    (pxl_data),    .pxl_ready   (pxl_ready),
        .fw_cyc      (fw_cyc),      .fw_stb      (fw_stb),
        .fw_we       (fw_we),       .fw_adr      (fw_adr),
        .fw_dat_w    (fw_dat_w),    .fw_sel      (fw_sel),
        .fw_dat_r    (fw_dat_r),    .fw_ack      (fw_ack)
    );

    ddr_arbiter u_arbiter (
        .clk_sys   (clk_sys),   .rst_n     (rst_n),
        .ld_cyc    (ld_cyc),    .ld_stb    (ld_stb),    .ld_we     (ld_we),
        .ld_adr    (ld_adr),    .ld_dat_w  (ld_dat_w),  .ld_sel    (ld_sel),
        .ld_dat_r  (ld_dat_r),  .ld_ack    (ld_ack),
        .fw_cyc    (fw_cyc),    .fw_stb    (fw_stb),    .fw_we     (fw_we),
        .fw_adr    (fw_adr),    .fw_dat_w  (fw_dat_w),  .fw_sel    (fw_sel),
        .fw_dat_r  (fw_dat_r),  .fw_ack    (fw_ack),
        .ddr_cyc   (ddr_cyc),   .ddr_stb   (ddr_stb),   .ddr_we    (ddr_we),
        .ddr_adr   (ddr_adr),   .ddr_dat_w (ddr_dat_w), .ddr_sel   (ddr_sel),
        .ddr_dat_r (ddr_dat_r), .ddr_ack   (ddr_ack)
    );

endmodule

// File: tb_ddr_model.sv
// Wishbone classic memory model standing in for the external DDR.
// Acknowledges each request after 1 to 4 cycles and honours sel on writes.
// The testbench preloads and inspects mem directly.

`timescale 1ns/1ns

module tb_ddr_model import ddr_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst_n,
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  ddr_addr_t adr,
    input  ddr_data_t dat_w,
    input  ddr_sel_t  sel,
    output ddr_data_t dat_r,
    output logic      ack
);

    ddr_data_t   mem [0:4095];
    logic [31:0] rng;
    logic [1:0]  wait_left;
    logic        busy;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    always @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            ack       <= 1'b0;
            busy      <= 1'b0;
            wait_left <= '0;
            dat_r     <= '0;
            rng       <= 32'h9bfe;
        end else begin
            ack <= 1'b0;
            if (cyc && stb && !ack) begin
                if (!busy) begin
                    // New request, pick its latency
                    busy      <= 1'b1;
                    wait_left <= rng[1:0];
                    rng       <= xorshift32(rng);
                end else if (wait_left != '0) begin
                    wait_left <= wait_left - 2'd1;
                end else begin
                    busy <= 1'b0;
                    ack  <= 1'b1;
                    if (we) begin
                        for (int i = 0; i < 8; i++) begin
                            if (sel[i]) begin
                                mem[adr[11:0]][8*i +: 8] <= dat_w[8*i +: 8];
                            end
                        end
                    end else begin
                        dat_r <= mem[adr[11:0]];
                    end
                end
            end
        end
    end

endmodule

// File: tb_ddr_assertions.sv
// Protocol checks on the external DDR Wishbone port.
// Bound into every instance of the top level.

`timescale 1ns/1ns

module tb_ddr_assertions import ddr_pkg::*; (
    input logic      clk_sys,
    input logic      rst_n,
    input logic      ddr_cyc,
    input logic      ddr_stb,
    input logic      ddr_we,
    input ddr_addr_t ddr_adr,
    input ddr_data_t ddr_dat_w,
    input logic      ddr_ack
);

    // Number of assertion failures so far
    int fail_count = 0;

    stb_needs_cyc: assert property (@(posedge clk_sys) disable iff (!rst_n)
        ddr_stb |-> ddr_cyc)
        else begin
            $error("DDR stb high without cyc");
            fail_count++;
        end

    // ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge clk_sys) disable iff (!rst_n)
        ddr_ack |=> !ddr_ack)
        else begin
            $error("DDR ack high for two cycles");
            fail_count++;
        end

    request_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
        (ddr_stb && !ddr_ack) |=> (ddr_stb && $stable(ddr_adr)
            && $stable(ddr_dat_w) && $stable(ddr_we)))
        else begin
            $error("DDR request changed before ack");
            fail_count++;
        end

endmodule

bind mister_ddr_top tb_ddr_assertions u_assertions (.*);

// File: tb_mister_ddr_top.sv
// Directed testbench for the DDR sharing core. Runs ROM downloads with and
// without back-pressure, frame writes, and both together against the DDR model.

`timescale 1ns/1ns

module tb_mister_ddr_top import ddr_pkg::*, game_pkg::*;;

    localparam ddr_addr_t LOAD_BASE = 'h100;
    localparam ddr_addr_t FB_BASE   = 'h800;
    localparam int        TIMEOUT   = 1000;

    logic       clk_sys, rst_n, dl_start, prog_rdy, frame_start, pxl_valid;
    load_len_t  dl_len;
    pixel_t     pxl_data;
    logic       downloading, prog_we, pxl_ready;
    prog_addr_t prog_addr;
    prog_byte_t prog_data;
    logic       ddr_cyc, ddr_stb, ddr_we, ddr_ack;
    ddr_addr_t  ddr_adr;
    ddr_data_t  ddr_dat_w, ddr_dat_r;
    ddr_sel_t   ddr_sel;
    logic [31:0] rng;

    mister_ddr_top #(.LOAD_BASE(LOAD_BASE), .FB_BASE(FB_BASE)) dut (.*);

    tb_ddr_model model (
        .clk_sys (clk_sys), .rst_n (rst_n), .cyc (ddr_cyc), .stb (ddr_stb),
        .we (ddr_we), .adr (ddr_adr), .dat_w (ddr_dat_w), .sel (ddr_sel),
        .dat_r (ddr_dat_r), .ack (ddr_ack)
    );

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ROM image pattern, a function of the whole word address
    function automatic ddr_data_t rom_word(input ddr_addr_t a);
        logic [31:0] x;
        x = 32'(a);
        return {x * 32'h9e37_79b9, x ^ 32'hc3a5_0f1e};
    endfunction

    task automatic stop_run(input string why);
        if (why != "") $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_timeout(inout int n, input string what);
        n++;
        if (n > TIMEOUT) stop_run({"Timeout while waiting for ", what});
    endtask

    task automatic check_byte(input string name, input prog_byte_t got, input prog_byte_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stop_run("");
        end
    endtask

    task automatic check_addr(input string name, input prog_addr_t got, input prog_addr_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stop_run("");
        end
    endtask

    task automatic check_word(input string name, input ddr_data_t got, input ddr_data_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stop_run("");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            stop_run("");
        end
    endtask

    // Any protocol assertion failure on the DDR port ends the run
    always @(negedge clk_sys) begin
        if (dut.u_assertions.fail_count != 0) begin
            stop_run("DDR bus protocol assertion failed");
        end
    end

    task automatic check_reset_state();
        check_bit("downloading", downloading, 1'b0);
        check_bit("prog_we", prog_we, 1'b0);
        check_bit("ddr_cyc", ddr_cyc, 1'b0);
        check_bit("pxl_ready", pxl_ready, 1'b1);
    endtask

    // Byte taken when prog_we and prog_rdy are both high at a rising edge
    task automatic run_download(input int words, input bit stall);
        ddr_data_t exp_word;
        int        got;
        int        n;
        got = 0;
        n = 0;
        @(negedge clk_sys);
        dl_len = load_len_t'(words);
        dl_start = 1'b1;
        @(negedge clk_sys);
        dl_start = 1'b0;
        check_bit("downloading", downloading, 1'b1);
        while (got < 8 * words) begin
            @(negedge clk_sys);
            rng = xorshift32(rng);
            prog_rdy = stall ? (rng[1:0] != 2'b00) : 1'b1;
            // Second start in mid transfer, must be ignored
            dl_start = (got == 4);
            if (ddr_cyc && !ddr_we) begin
                check_bit("prog_we during read", prog_we, 1'b0);
                check_bit("read on word boundary", (got % 8) == 0, 1'b1);
            end
            if (prog_we && prog_rdy) begin
                exp_word = rom_word(LOAD_BASE + ddr_addr_t'(got / 8));
                check_addr("prog_addr", prog_addr, prog_addr_t'(got));
                check_byte("prog_data", prog_data, exp_word[8*(got%8) +: 8]);
                got++;
            end
            check_timeout(n, "ROM bytes");
        end
        @(negedge clk_sys);
        dl_start = 1'b0;
        prog_rdy = 1'b0;
        check_bit("downloading", downloading, 1'b0);
    endtask

    task automatic send_frame(input int count);
        pixel_t    pix [$];
        ddr_data_t exp_word;
        int        sent;
        int        acked;
        int        n;
        sent = 0;
        acked = 0;
        n = 0;
        for (int i = 0; i < count; i++) begin
            rng = xorshift32(rng);
            pix.push_back(rng[15:0]);
        end
        @(negedge clk_sys);
        frame_start = 1'b1;
        pxl_valid = 1'b0;
        while (sent < count || acked < count / 4) begin
            @(negedge clk_sys);
            frame_start = 1'b0;
            // Collector and pending word both full only with 8 pixels held
            check_bit("pxl_ready", pxl_ready, (sent - 4 * acked) < 8);
            if (ddr_ack && ddr_we) acked++;
            pxl_valid = (sent < count);
            if (sent < count) pxl_data = pix[sent];
            if (pxl_valid && pxl_ready) sent++;
            check_timeout(n, "frame buffer writes");
        end
        @(negedge clk_sys);
        pxl_valid = 1'b0;
        for (int j = 0; j < count / 4; j++) begin
            exp_word = {pix[4*j+3], pix[4*j+2], pix[4*j+1], pix[4*j]};
            check_word($sformatf("mem[%0h]", FB_BASE + j), model.mem[FB_BASE + j], exp_word);
        end
    endtask

    task automatic run_concurrent();
        fork
            run_download(3, 1'b1);
            send_frame(12);
        join
    endtask

    initial begin
        rng = 32'h9bfe;
        rst_n = 1'b0;
        dl_start = 1'b0;
        dl_len = '0;
        prog_rdy = 1'b0;
        frame_start = 1'b0;
        pxl_valid = 1'b0;
        pxl_data = '0;
        for (int i = 0; i < 8; i++) begin
            model.mem[LOAD_BASE + i] = rom_word(LOAD_BASE + ddr_addr_t'(i));
        end
        repeat (4) @(negedge clk_sys);
        rst_n = 1'b1;
        check_reset_state();
        run_download(3, 1'b0);
        run_download(3, 1'b1);
        send_frame(12);
        // Restart after frame_start goes back to the frame buffer base
        send_frame(4);
        run_concurrent();
        if (dut.u_assertions.fail_count != 0) begin
            stop_run("DDR bus protocol assertion failed");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// File: filelist.f
ddr_pkg.sv
game_pkg.sv
rom_loader.sv
frame_writer.sv
ddr_arbiter.sv
mister_ddr_top.sv
tb_ddr_model.sv
tb_ddr_assertions.sv
tb_mister_ddr_top.sv
